// File: include/exu_defs.svh
/*
 * Width, size and reset-value macros for the integer execute unit.
 * Included by the package and by every RTL module that sizes a port
 * or a register from these values.
 */
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// Datapath widths
`define EXU_XLEN         32
`define EXU_PCW          31
`define EXU_BRIMM_W      12

// Global branch history length
`define EXU_GHR_W        8

// Quotient bits produced by the divider, one per RUN cycle
`define EXU_DIV_STEPS    32

// Reset values
`define EXU_GHR_RST_VAL  {`EXU_GHR_W{1'b0}}
`define EXU_XRES_RST_VAL {`EXU_XLEN{1'b0}}

`endif

// File: design/exu_pkg.sv
/*
 * Shared types of the execute unit: ALU opcodes, the decode packets
 * sent from D, the flush packet and the divider state encoding.
 * Modules refer to these by scoped names.
 */
`include "exu_defs.svh"

package exu_pkg;

   // ALU and branch opcodes
   typedef enum logic [3:0] {
      ALU_ADD = 4'd0,
      ALU_SUB = 4'd1,
      ALU_AND = 4'd2,
      ALU_OR  = 4'd3,
      ALU_XOR = 4'd4,
      ALU_SLL = 4'd5,
      ALU_SRL = 4'd6,
      ALU_SLT = 4'd7,   // Signed compare
      ALU_BEQ = 4'd8,
      ALU_BNE = 4'd9,
      ALU_BLT = 4'd10,  // Signed
      ALU_BGE = 4'd11,  // Signed
      ALU_JAL = 4'd12
   } alu_op_e;

   typedef struct packed {
      logic    valid;
      alu_op_e op;
   } alu_pkt_t;

   // X-stage bypass wins over R-stage bypass
   typedef struct packed {
      logic from_x;
      logic from_r;
   } byp_sel_t;

   typedef struct packed {
      logic valid;
      logic pred_taken;  // Prediction made at fetch
   } br_pkt_t;

   typedef struct packed {
      logic                flush;
      logic [`EXU_PCW-1:0] path;  // Redirect target, PC bits 31:1
   } flush_pkt_t;

   typedef struct packed {
      logic valid;
      logic rem;  // Return remainder instead of quotient
   } div_pkt_t;

   typedef enum logic [1:0] {
      DIV_IDLE = 2'd0,
      DIV_RUN  = 2'd1,
      DIV_DONE = 2'd2
   } div_state_e;

endpackage

// File: design/exu_operand_sel.sv
/*
 * D-stage operand selection. Builds rs1 and rs2 from the X/R bypass,
 * the instruction PC, the GPR read data and the immediate.
 * Purely combinational.
 */
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_operand_sel (
   input  exu_pkg::byp_sel_t     i_rs1_byp_d,
   input  exu_pkg::byp_sel_t     i_rs2_byp_d,
   input  logic [`EXU_XLEN-1:0]  i_result_x,     // X-stage result
   input  logic [`EXU_XLEN-1:0]  i_result_r,     // R-stage result
   input  logic [`EXU_XLEN-1:0]  i_gpr_rs1_d,
   input  logic [`EXU_XLEN-1:0]  i_gpr_rs2_d,
   input  logic                  i_rs1_en_d,
   input  logic                  i_rs2_en_d,
   input  logic                  i_select_pc_d,  // PC to rs1, for jal and auipc
   input  logic [`EXU_PCW-1:0]   i_pc_d,
   input  logic [`EXU_XLEN-1:0]  i_immed_d,
   output logic [`EXU_XLEN-1:0]  o_rs1_d,
   output logic [`EXU_XLEN-1:0]  o_rs2_d
);

   logic                 rs1_byp_en;
   logic                 rs2_byp_en;
   logic [`EXU_XLEN-1:0] rs1_byp_data;
   logic [`EXU_XLEN-1:0] rs2_byp_data;

   // The younger X result is the more recent copy of the register
   function automatic logic [`EXU_XLEN-1:0] byp_mux(input exu_pkg::byp_sel_t sel,
                                                    input logic [`EXU_XLEN-1:0] res_x,
                                                    input logic [`EXU_XLEN-1:0] res_r);
      return sel.from_x ? res_x : res_r;
   endfunction

   assign rs1_byp_en   = i_rs1_byp_d.from_x | i_rs1_byp_d.from_r;
   assign rs2_byp_en   = i_rs2_byp_d.from_x | i_rs2_byp_d.from_r;
   assign rs1_byp_data = byp_mux(i_rs1_byp_d, i_result_x, i_result_r);
   assign rs2_byp_data = byp_mux(i_rs2_byp_d, i_result_x, i_result_r);

   assign o_rs1_d = rs1_byp_en    ? rs1_byp_data     :
                    i_select_pc_d ? {i_pc_d, 1'b0}   :  // Halfword PC, bit 0 clear
                    i_rs1_en_d    ? i_gpr_rs1_d      :
                                    '0;

   assign o_rs2_d = rs2_byp_en    ? rs2_byp_data     :
                    i_rs2_en_d    ? i_gpr_rs2_d      :
                                    i_immed_d;

endmodule

// File: design/exu_alu.sv
/*
 * Single-cycle ALU. Computes the result at D and registers it into X,
 * resolves branches at D and raises the upper flush with the redirect
 * path in the same cycle on a mispredict.
 */
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_alu (
   input  logic                     clk,
   input  logic                     i_rst_n,
   input  exu_pkg::alu_pkt_t        i_ap,
   input  exu_pkg::br_pkt_t         i_br_p,
   input  logic [`EXU_XLEN-1:0]     i_a_d,
   input  logic [`EXU_XLEN-1:0]     i_b_d,
   input  logic [`EXU_PCW-1:0]      i_pc_d,
   input  logic [`EXU_BRIMM_W-1:0]  i_br_immed_d,   // Offset in halfwords
   output logic [`EXU_XLEN-1:0]     o_result_x,
   output exu_pkg::flush_pkt_t      o_upper_flush,
   output logic                     o_taken_d,
   output logic                     o_br_valid_d
);

   localparam int XLEN  = `EXU_XLEN;
   localparam int PCW   = `EXU_PCW;
   localparam int BRW   = `EXU_BRIMM_W;
   localparam int SHW   = $clog2(XLEN);

   logic [XLEN-1:0] result_d;
   logic [PCW-1:0]  pc_inc_d;
   logic [PCW-1:0]  br_offset_d;
   logic [PCW-1:0]  target_d;
   logic            lt_d;
   logic            is_cmp_d;
   logic            cond_d;

   assign lt_d        = $signed(i_a_d) < $signed(i_b_d);
   assign pc_inc_d    = i_pc_d + PCW'(2);                                  // PC+4
   assign br_offset_d = {{(PCW-BRW){i_br_immed_d[BRW-1]}}, i_br_immed_d};  // Sign extend

   always_comb begin
      result_d = '0;
      is_cmp_d = 1'b0;
      cond_d   = 1'b0;
      case (i_ap.op)
         exu_pkg::ALU_ADD: result_d = i_a_d + i_b_d;
         exu_pkg::ALU_SUB: result_d = i_a_d - i_b_d;
         exu_pkg::ALU_AND: result_d = i_a_d & i_b_d;
         exu_pkg::ALU_OR:  result_d = i_a_d | i_b_d;
         exu_pkg::ALU_XOR: result_d = i_a_d ^ i_b_d;
         exu_pkg::ALU_SLL: result_d = i_a_d << i_b_d[SHW-1:0];
         exu_pkg::ALU_SRL: result_d = i_a_d >> i_b_d[SHW-1:0];
         exu_pkg::ALU_SLT: result_d = {{(XLEN-1){1'b0}}, lt_d};
         exu_pkg::ALU_BEQ: begin
            is_cmp_d = 1'b1;
            cond_d   = (i_a_d == i_b_d);
         end
         exu_pkg::ALU_BNE: begin
            is_cmp_d = 1'b1;
            cond_d   = (i_a_d != i_b_d);
         end
         exu_pkg::ALU_BLT: begin
            is_cmp_d = 1'b1;
            cond_d   = lt_d;
         end
         exu_pkg::ALU_BGE: begin
            is_cmp_d = 1'b1;
            cond_d   = ~lt_d;
         end
         exu_pkg::ALU_JAL: result_d = {pc_inc_d, 1'b0};  // Link address
         default:          result_d = '0;
      endcase
   end

   // Branch resolution at D
   assign o_taken_d    = i_ap.valid & ((i_ap.op == exu_pkg::ALU_JAL) | (is_cmp_d & cond_d));
   assign o_br_valid_d = i_br_p.valid & i_ap.valid;
   assign target_d     = o_taken_d ? (i_pc_d + br_offset_d) : pc_inc_d;

   assign o_upper_flush.flush = o_br_valid_d & (o_taken_d ^ i_br_p.pred_taken);
   assign o_upper_flush.path  = target_d;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_result_x <= `EXU_XRES_RST_VAL;
      end else if (i_ap.valid) begin
         o_result_x <= result_d;
      end
   end

endmodule

// File: design/exu_mul.sv
/*
 * Unsigned multiplier, one pipeline stage. The low half of the
 * product of the D operands is available at X.
 */
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_mul (
   input  logic                  clk,
   input  logic                  i_rst_n,
   input  logic                  i_valid_d,
   input  logic [`EXU_XLEN-1:0]  i_a_d,
   input  logic [`EXU_XLEN-1:0]  i_b_d,
   output logic [`EXU_XLEN-1:0]  o_product_x
);

   localparam int XLEN = `EXU_XLEN;

   logic [XLEN-1:0]   a_gated;
   logic [XLEN-1:0]   b_gated;
   logic [2*XLEN-1:0] product_d;

   // Keep the array quiet when no multiply is issued
   assign a_gated   = i_a_d & {XLEN{i_valid_d}};
   assign b_gated   = i_b_d & {XLEN{i_valid_d}};
   assign product_d = a_gated * b_gated;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_product_x <= `EXU_XRES_RST_VAL;
      end else if (i_valid_d) begin
         o_product_x <= product_d[XLEN-1:0];  // Low word only
      end
   end

endmodule

// File: design/exu_div.sv
/*
 * Iterative unsigned restoring divider. One quotient bit per cycle in
 * RUN, then a DONE cycle that loads the write-back register. The result
 * is written back EXU_DIV_STEPS+2 cycles after the start at D.
 * A cancel while busy drops the operation without write-back.
 */
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_div (
   input  logic                  clk,
   input  logic                  i_rst_n,
   input  exu_pkg::div_pkt_t     i_dp,
   input  logic                  i_cancel,
   input  logic [`EXU_XLEN-1:0]  i_dividend_d,
   input  logic [`EXU_XLEN-1:0]  i_divisor_d,
   output logic                  o_wren,
   output logic [`EXU_XLEN-1:0]  o_result,
   output logic                  o_busy
);

   localparam int XLEN  = `EXU_XLEN;
   localparam int STEPS = `EXU_DIV_STEPS;
   localparam int CNT_W = $clog2(STEPS);

   exu_pkg::div_state_e state_q;
   logic [CNT_W-1:0]    cnt_q;
   logic [XLEN-1:0]     rem_q;      // Partial remainder
   logic [XLEN-1:0]     quot_q;     // Dividend shifts out, quotient shifts in
   logic [XLEN-1:0]     divisor_q;
   logic                rem_sel_q;
   logic [XLEN:0]       shifted;
   logic [XLEN:0]       diff;
   logic                ge;
   logic                start;

   assign o_busy  = (state_q != exu_pkg::DIV_IDLE);
   assign start   = (state_q == exu_pkg::DIV_IDLE) & i_dp.valid;

   // One restoring step
   assign shifted = {rem_q, quot_q[XLEN-1]};
   assign diff    = shifted - {1'b0, divisor_q};
   assign ge      = (shifted >= {1'b0, divisor_q});

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state_q <= exu_pkg::DIV_IDLE;
         cnt_q   <= '0;
      end else if (o_busy & i_cancel) begin
         state_q <= exu_pkg::DIV_IDLE;  // Killed, no write-back
      end else begin
         case (state_q)
            exu_pkg::DIV_IDLE: begin
               if (i_dp.valid) begin
                  state_q <= exu_pkg::DIV_RUN;
                  cnt_q   <= '0;
               end
            end
            exu_pkg::DIV_RUN: begin
               cnt_q <= cnt_q + 1'b1;
               if (cnt_q == CNT_W'(STEPS-1)) begin
                  state_q <= exu_pkg::DIV_DONE;
               end
            end
            exu_pkg::DIV_DONE: state_q <= exu_pkg::DIV_IDLE;
            default:           state_q <= exu_pkg::DIV_IDLE;
         endcase
      end
   end

   // With a zero divisor every step subtracts nothing, so the quotient
   // fills with ones and the remainder ends up holding the dividend
   always_ff @(posedge clk) begin
      if (start) begin
         rem_q     <= '0;
         quot_q    <= i_dividend_d;
         divisor_q <= i_divisor_d;
         rem_sel_q <= i_dp.rem;
      end else if (state_q == exu_pkg::DIV_RUN) begin
         rem_q  <= ge ? diff[XLEN-1:0] : shifted[XLEN-1:0];
         quot_q <= {quot_q[XLEN-2:0], ge};
      end
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_wren   <= 1'b0;
         o_result <= `EXU_XRES_RST_VAL;
      end else begin
         o_wren <= (state_q == exu_pkg::DIV_DONE) & ~i_cancel;  // Single-cycle pulse
         if (state_q == exu_pkg::DIV_DONE) begin
            o_result <= rem_sel_q ? rem_q : quot_q;
         end
      end
   end

   // Decode must stall a second divide until this one retires
   a_no_start_while_busy: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_dp.valid |-> !o_busy)
      else $error("divide issued while divider busy");

endmodule

// File: design/exu_ctl.sv
/*
 * Execute-unit control. Picks the X result between ALU and multiplier,
 * keeps the global branch history at X, arbitrates the lower and upper
 * flush sources and turns cancel or lower flush into a divider kill.
 */
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_ctl (
   input  logic                   clk,
   input  logic                   i_rst_n,
   input  logic                   i_mul_valid_d,
   input  logic [`EXU_XLEN-1:0]   i_alu_result_x,
   input  logic [`EXU_XLEN-1:0]   i_mul_product_x,
   input  exu_pkg::flush_pkt_t    i_upper_flush,    // Mispredict from D
   input  logic                   i_flush_lower_r,  // Older flush from R
   input  logic [`EXU_PCW-1:0]    i_flush_path_r,
   input  logic                   i_br_valid_d,
   input  logic                   i_taken_d,
   input  logic                   i_div_cancel_ext,
   input  logic                   i_div_busy,
   output logic [`EXU_XLEN-1:0]   o_result_x,
   output exu_pkg::flush_pkt_t    o_flush,
   output logic [`EXU_GHR_W-1:0]  o_ghr,
   output logic                   o_div_kill
);

   localparam int GHR_W = `EXU_GHR_W;

   logic mul_valid_x;
   logic ghr_upd_d;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         mul_valid_x <= 1'b0;
      end else begin
         mul_valid_x <= i_mul_valid_d;
      end
   end

   assign o_result_x = mul_valid_x ? i_mul_product_x : i_alu_result_x;

   // A lower flush kills the branch at D, so history skips it
   assign ghr_upd_d = i_br_valid_d & ~i_flush_lower_r;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_ghr <= `EXU_GHR_RST_VAL;
      end else if (ghr_upd_d) begin
         o_ghr <= {o_ghr[GHR_W-2:0], i_taken_d};  // Newest outcome in bit 0
      end
   end

   // The R-stage flush is older and takes priority
   always_comb begin
      o_flush.flush = i_flush_lower_r | i_upper_flush.flush;
      if (i_flush_lower_r) begin
         o_flush.path = i_flush_path_r;
      end else if (i_upper_flush.flush) begin
         o_flush.path = i_upper_flush.path;
      end else begin
         o_flush.path = '0;
      end
   end

   assign o_div_kill = (i_div_cancel_ext | i_flush_lower_r) & i_div_busy;

   // Any flush leaving the unit comes from R or from a valid branch at D
   a_flush_source: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_flush.flush |-> (i_flush_lower_r || i_br_valid_d))
      else $error("flush raised without a lower flush or a valid branch");

endmodule

// File: design/exu_top.sv
/*
 * Integer execute unit top level. Connects operand selection, ALU,
 * multiplier, divider and control. The X result is fed back to the
 * operand bypass.
 */
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_top (
   input  logic                     clk,
   input  logic                     i_rst_n,
   input  exu_pkg::alu_pkt_t        i_ap,
   input  logic                     i_mul_valid_d,
   input  exu_pkg::div_pkt_t        i_div_p,
   input  logic [`EXU_XLEN-1:0]     i_gpr_rs1_d,
   input  logic [`EXU_XLEN-1:0]     i_gpr_rs2_d,
   input  logic                     i_rs1_en_d,
   input  logic                     i_rs2_en_d,
   input  logic [`EXU_XLEN-1:0]     i_immed_d,
   input  logic                     i_select_pc_d,
   input  logic [`EXU_PCW-1:0]      i_pc_d,
   input  logic [`EXU_BRIMM_W-1:0]  i_br_immed_d,
   input  exu_pkg::byp_sel_t        i_rs1_byp_d,
   input  exu_pkg::byp_sel_t        i_rs2_byp_d,
   input  logic [`EXU_XLEN-1:0]     i_result_r,
   input  exu_pkg::br_pkt_t         i_br_p,
   input  logic                     i_div_cancel,
   input  logic                     i_flush_lower_r,
   input  logic [`EXU_PCW-1:0]      i_flush_path_r,
   output logic [`EXU_XLEN-1:0]     o_result_x,
   output exu_pkg::flush_pkt_t      o_flush,
   output logic [`EXU_GHR_W-1:0]    o_ghr,
   output logic                     o_div_wren,
   output logic [`EXU_XLEN-1:0]     o_div_result,
   output logic                     o_div_busy
);

   logic [`EXU_XLEN-1:0] rs1_d;
   logic [`EXU_XLEN-1:0] rs2_d;
   logic [`EXU_XLEN-1:0] alu_result_x;
   logic [`EXU_XLEN-1:0] mul_product_x;
   exu_pkg::flush_pkt_t  upper_flush;
   logic                 taken_d;
   logic                 br_valid_d;
   logic                 div_kill;

   exu_operand_sel operand_sel_inst (
      .i_rs1_byp_d(i_rs1_byp_d), .i_rs2_byp_d(i_rs2_byp_d),
      .i_result_x(o_result_x), .i_result_r(i_result_r),
      .i_gpr_rs1_d(i_gpr_rs1_d), .i_gpr_rs2_d(i_gpr_rs2_d),
      .i_rs1_en_d(i_rs1_en_d), .i_rs2_en_d(i_rs2_en_d),
      .i_select_pc_d(i_select_pc_d), .i_pc_d(i_pc_d), .i_immed_d(i_immed_d),
      .o_rs1_d(rs1_d), .o_rs2_d(rs2_d));

   exu_alu alu_inst (
      .clk(clk), .i_rst_n(i_rst_n), .i_ap(i_ap), .i_br_p(i_br_p),
      .i_a_d(rs1_d), .i_b_d(rs2_d), .i_pc_d(i_pc_d), .i_br_immed_d(i_br_immed_d),
      .o_result_x(alu_result_x), .o_upper_flush(upper_flush),
      .o_taken_d(taken_d), .o_br_valid_d(br_valid_d));

   exu_mul mul_inst (
      .clk(clk), .i_rst_n(i_rst_n), .i_valid_d(i_mul_valid_d),
      .i_a_d(rs1_d), .i_b_d(rs2_d), .o_product_x(mul_product_x));

   exu_div div_inst (
      .clk(clk), .i_rst_n(i_rst_n), .i_dp(i_div_p), .i_cancel(div_kill),
      .i_dividend_d(rs1_d), .i_divisor_d(rs2_d),
      .o_wren(o_div_wren), .o_result(o_div_result), .o_busy(o_div_busy));

   exu_ctl ctl_inst (
      .clk(clk), .i_rst_n(i_rst_n), .i_mul_valid_d(i_mul_valid_d),
      .i_alu_result_x(alu_result_x), .i_mul_product_x(mul_product_x),
      .i_upper_flush(upper_flush), .i_flush_lower_r(i_flush_lower_r),
      .i_flush_path_r(i_flush_path_r), .i_br_valid_d(br_valid_d), .i_taken_d(taken_d),
      .i_div_cancel_ext(i_div_cancel), .i_div_busy(o_div_busy),
      .o_result_x(o_result_x), .o_flush(o_flush), .o_ghr(o_ghr), .o_div_kill(div_kill));

endmodule

// File: sim/tb_exu_top.sv
/*
 * Testbench for the execute unit. Drives D-stage traffic on the falling
 * edge, keeps a reference model of the X result, flush, GHR and divider,
 * and compares it with the DUT ports through concurrent assertions.
 */
`timescale 1ns/1ps
`include "exu_defs.svh"

module tb_exu_top;

   localparam int XLEN = `EXU_XLEN;
   localparam int PCW = `EXU_PCW;
   localparam int TIMEOUT_CYCLES = 3000;  // Far above the roughly 450 cycles of all tests

   logic clk = 1'b0;
   logic i_rst_n;
   exu_pkg::alu_pkt_t i_ap;
   logic i_mul_valid_d;
   exu_pkg::div_pkt_t i_div_p;
   logic [XLEN-1:0] i_gpr_rs1_d;
   logic [XLEN-1:0] i_gpr_rs2_d;
   logic i_rs1_en_d;
   logic i_rs2_en_d;
   logic [XLEN-1:0] i_immed_d;
   logic i_select_pc_d;
   logic [PCW-1:0] i_pc_d;
   logic [`EXU_BRIMM_W-1:0] i_br_immed_d;
   exu_pkg::byp_sel_t i_rs1_byp_d;
   exu_pkg::byp_sel_t i_rs2_byp_d;
   logic [XLEN-1:0] i_result_r;
   exu_pkg::br_pkt_t i_br_p;
   logic i_div_cancel;
   logic i_flush_lower_r;
   logic [PCW-1:0] i_flush_path_r;
   logic [XLEN-1:0] o_result_x;
   exu_pkg::flush_pkt_t o_flush;
   logic [`EXU_GHR_W-1:0] o_ghr;
   logic o_div_wren;
   logic [XLEN-1:0] o_div_result;
   logic o_div_busy;

   // Reference model state
   logic [XLEN-1:0] m_rs1, m_rs2, m_alu_d, m_alu_x, m_mul_x, m_result_x, m_div_res;
   logic m_mul_sel, m_taken, m_br_valid, m_div_wren;
   logic [PCW-1:0] m_target;
   exu_pkg::flush_pkt_t m_flush;
   logic [`EXU_GHR_W-1:0] m_ghr;
   int m_div_left;  // Cycles until write-back, 0 when idle
   int err_count = 0;
   int err_mark = 0;
   int tests_passed = 0;
   int tests_failed = 0;
   int cycle_count = 0;

   exu_top exu_top_inst (.*);

   always #20 clk = ~clk;

   function automatic logic [XLEN-1:0] alu_model(input exu_pkg::alu_op_e op,
                                                 input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b,
                                                 input logic [PCW-1:0] pc);
      logic [PCW-1:0] link;
      link = pc + PCW'(2);
      case (op)
         exu_pkg::ALU_ADD: return a + b;
         exu_pkg::ALU_SUB: return a - b;
         exu_pkg::ALU_AND: return a & b;
         exu_pkg::ALU_OR:  return a | b;
         exu_pkg::ALU_XOR: return a ^ b;
         exu_pkg::ALU_SLL: return a << b[4:0];
         exu_pkg::ALU_SRL: return a >> b[4:0];
         exu_pkg::ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         exu_pkg::ALU_JAL: return {link, 1'b0};  // Return address
         default:          return '0;            // Compares write no value
      endcase
   endfunction

   function automatic logic taken_model(input exu_pkg::alu_op_e op,
                                        input logic [XLEN-1:0] a,
                                        input logic [XLEN-1:0] b);
      case (op)
         exu_pkg::ALU_BEQ: return a == b;
         exu_pkg::ALU_BNE: return a != b;
         exu_pkg::ALU_BLT: return $signed(a) < $signed(b);
         exu_pkg::ALU_BGE: return $signed(a) >= $signed(b);
         exu_pkg::ALU_JAL: return 1'b1;
         default:          return 1'b0;
      endcase
   endfunction

   function automatic logic [XLEN-1:0] div_model(input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b,
                                                 input logic rem);
      if (b == '0) begin
         return rem ? a : '1;  // Divide by zero
      end
      return rem ? (a % b) : (a / b);
   endfunction

   assign m_result_x = m_mul_sel ? m_mul_x : m_alu_x;

   always_comb begin
      if (i_rs1_byp_d.from_x) m_rs1 = m_result_x;
      else if (i_rs1_byp_d.from_r) m_rs1 = i_result_r;
      else if (i_select_pc_d) m_rs1 = {i_pc_d, 1'b0};
      else if (i_rs1_en_d) m_rs1 = i_gpr_rs1_d;
      else m_rs1 = '0;
      if (i_rs2_byp_d.from_x) m_rs2 = m_result_x;
      else if (i_rs2_byp_d.from_r) m_rs2 = i_result_r;
      else if (i_rs2_en_d) m_rs2 = i_gpr_rs2_d;
      else m_rs2 = i_immed_d;
      m_alu_d = alu_model(i_ap.op, m_rs1, m_rs2, i_pc_d);
      m_taken = i_ap.valid & taken_model(i_ap.op, m_rs1, m_rs2);
      m_br_valid = i_br_p.valid & i_ap.valid;
      m_target = m_taken ? i_pc_d + PCW'($signed(i_br_immed_d)) : i_pc_d + PCW'(2);
      m_flush.flush = i_flush_lower_r | (m_br_valid & (m_taken != i_br_p.pred_taken));
      m_flush.path = i_flush_lower_r ? i_flush_path_r : m_target;
   end

   always @(posedge clk) begin
      if (!i_rst_n) begin
         m_alu_x <= '0;
         m_mul_x <= '0;
         m_mul_sel <= 1'b0;
         m_ghr <= '0;
         m_div_left <= 0;
         m_div_wren <= 1'b0;
      end else begin
         m_mul_sel <= i_mul_valid_d;
         if (i_mul_valid_d) m_mul_x <= m_rs1 * m_rs2;  // Low word of the product
         if (i_ap.valid) m_alu_x <= m_alu_d;
         if (m_br_valid && !i_flush_lower_r) m_ghr <= {m_ghr[`EXU_GHR_W-2:0], m_taken};
         m_div_wren <= 1'b0;
         if (m_div_left != 0 && (i_div_cancel || i_flush_lower_r)) begin
            m_div_left <= 0;
         end else if (m_div_left != 0) begin
            m_div_left <= m_div_left - 1;
            m_div_wren <= (m_div_left == 1);
         end else if (i_div_p.valid) begin
            m_div_left <= `EXU_DIV_STEPS + 1;
            m_div_res <= div_model(m_rs1, m_rs2, i_div_p.rem);
         end
      end
   end

   task automatic report_mismatch(input string msg);
      $display("mismatch at %0t ns: %s", $time, msg);
      err_count++;
   endtask

   a_result_x: assert property (@(posedge clk) disable iff (!i_rst_n) o_result_x == m_result_x)
      else report_mismatch($sformatf("o_result_x %h, expected %h",
                                     $sampled(o_result_x), $sampled(m_result_x)));
   a_flush: assert property (@(posedge clk) disable iff (!i_rst_n)
      (o_flush.flush == m_flush.flush) && (!m_flush.flush || o_flush.path == m_flush.path))
      else report_mismatch($sformatf("o_flush %h, expected %h",
                                     $sampled(o_flush), $sampled(m_flush)));
   a_ghr: assert property (@(posedge clk) disable iff (!i_rst_n) o_ghr == m_ghr)
      else report_mismatch($sformatf("o_ghr %h, expected %h", $sampled(o_ghr), $sampled(m_ghr)));
   a_div_busy: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_div_busy == (m_div_left != 0))
      else report_mismatch($sformatf("o_div_busy %b, model cycles left %0d",
                                     $sampled(o_div_busy), $sampled(m_div_left)));
   a_div_wren: assert property (@(posedge clk) disable iff (!i_rst_n) o_div_wren == m_div_wren)
      else report_mismatch($sformatf("o_div_wren %b, expected %b",
                                     $sampled(o_div_wren), $sampled(m_div_wren)));
   a_div_result: assert property (@(posedge clk) disable iff (!i_rst_n)
      m_div_wren |-> o_div_result == m_div_res)
      else report_mismatch($sformatf("o_div_result %h, expected %h",
                                     $sampled(o_div_result), $sampled(m_div_res)));

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Simulation failed");
         $finish;
      end
   end

   task automatic drive_idle();
      i_ap = '0;
      i_mul_valid_d = 1'b0;
      i_div_p = '0;
      i_br_p = '0;
      i_rs1_byp_d = '0;
      i_rs2_byp_d = '0;
      i_select_pc_d = 1'b0;
      i_div_cancel = 1'b0;
      i_flush_lower_r = 1'b0;
   endtask

   // Drains the pipe so the last X result is checked, then scores the test
   task automatic end_test(input string name);
      @(negedge clk);
      drive_idle();
      repeat (2) @(negedge clk);
      if (err_count == err_mark) tests_passed++;
      else tests_failed++;
      $display("test %-16s %s, %0d errors", name, (err_count == err_mark) ? "ok" : "FAILED",
               err_count - err_mark);
      err_mark = err_count;
   endtask

   task automatic alu_ops_seq();
      int op;
      for (op = 0; op <= 12; op++) begin
         repeat (3) begin
            @(negedge clk);
            drive_idle();
            i_ap.valid = 1'b1;
            i_ap.op = exu_pkg::alu_op_e'(4'(op));
            i_gpr_rs1_d = $urandom;
            i_gpr_rs2_d = $urandom;
            i_rs1_en_d = 1'b1;
            i_rs2_en_d = 1'b1;
            i_pc_d = $urandom;
         end
      end
      end_test("alu_ops");
   endtask

   task automatic bypass_seq();
      repeat (24) begin
         @(negedge clk);
         drive_idle();
         i_ap.valid = 1'b1;
         i_ap.op = exu_pkg::alu_op_e'(4'($urandom % 8));
         i_rs1_byp_d = 2'($urandom);
         i_rs2_byp_d = 2'($urandom);
         i_select_pc_d = 1'($urandom);
         i_rs1_en_d = 1'($urandom);
         i_rs2_en_d = 1'($urandom);
         i_gpr_rs1_d = $urandom;
         i_gpr_rs2_d = $urandom;
         i_immed_d = $urandom;
         i_result_r = $urandom;
         i_pc_d = $urandom;
      end
      end_test("bypass_pc");
   endtask

   task automatic multiply_seq();
      repeat (14) begin
         @(negedge clk);
         drive_idle();
         i_mul_valid_d = 1'b1;
         i_rs1_byp_d.from_x = ($urandom % 4 == 0);  // Chain on the previous product
         i_gpr_rs1_d = $urandom;
         i_gpr_rs2_d = $urandom;
         i_rs1_en_d = 1'b1;
         i_rs2_en_d = 1'b1;
      end
      end_test("multiply");
   endtask

   task automatic branch_seq(input bit lower_flush);
      repeat (20) begin
         @(negedge clk);
         drive_idle();
         i_ap.valid = 1'b1;
         i_ap.op = exu_pkg::alu_op_e'(4'(8 + $urandom % 5));
         i_br_p.valid = 1'b1;
         i_br_p.pred_taken = 1'($urandom);
         i_gpr_rs1_d = $urandom;
         i_gpr_rs2_d = ($urandom % 2) ? i_gpr_rs1_d : $urandom;
         i_rs1_en_d = 1'b1;
         i_rs2_en_d = 1'b1;
         i_pc_d = $urandom;
         i_br_immed_d = $urandom;
         i_flush_lower_r = lower_flush & 1'($urandom);
         i_flush_path_r = $urandom;
      end
      end_test(lower_flush ? "flush_priority" : "branch");
   endtask

   task automatic divide_op(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                            input logic rem, input int kill_after, input bit by_flush);
      @(negedge clk);
      drive_idle();
      i_div_p.valid = 1'b1;
      i_div_p.rem = rem;
      i_gpr_rs1_d = a;
      i_gpr_rs2_d = b;
      i_rs1_en_d = 1'b1;
      i_rs2_en_d = 1'b1;
      @(negedge clk);
      drive_idle();
      if (kill_after > 0) begin
         repeat (kill_after) @(negedge clk);
         i_div_cancel = !by_flush;
         i_flush_lower_r = by_flush;
         i_flush_path_r = $urandom;
         @(negedge clk);
         drive_idle();
      end
      while (o_div_busy) @(negedge clk);
   endtask

   task automatic divide_seq();
      repeat (5) divide_op($urandom, $urandom >> ($urandom % 32), 1'($urandom), 0, 1'b0);
      divide_op($urandom, '0, 1'b0, 0, 1'b0);
      divide_op($urandom, '0, 1'b1, 0, 1'b0);
      divide_op($urandom, $urandom % 1000, 1'b0, 10, 1'b0);  // Cancel mid-run
      divide_op($urandom, $urandom % 1000, 1'b1, 20, 1'b1);  // Killed by lower flush
      end_test("divide");
   endtask

   initial begin
      int seed;
      i_rst_n = 1'b0;
      drive_idle();
      i_gpr_rs1_d = '0;
      i_gpr_rs2_d = '0;
      i_rs1_en_d = 1'b0;
      i_rs2_en_d = 1'b0;
      i_immed_d = '0;
      i_pc_d = '0;
      i_br_immed_d = '0;
      i_result_r = '0;
      i_flush_path_r = '0;
      seed = $urandom(23045);
      repeat (3) @(posedge clk);
      @(negedge clk);
      i_rst_n = 1'b1;
      alu_ops_seq();
      bypass_seq();
      multiply_seq();
      branch_seq(1'b0);
      divide_seq();
      branch_seq(1'b1);
      $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, err_count);
      if (tests_failed == 0 && err_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: exu_top.f
+incdir+include
design/exu_pkg.sv
design/exu_operand_sel.sv
design/exu_alu.sv
design/exu_mul.sv
design/exu_div.sv
design/exu_ctl.sv
design/exu_top.sv
sim/tb_exu_top.sv
